/* dv/matrix_calc_properties.sv */
// Concurrent assertions on the calculator top level
// Output marker, reset quiet period and error LED exclusivity
`timescale 1ns/1ps
`default_nettype none

module matrix_calc_properties (
  input wire       clk,
  input wire       reset,
  input wire       out_valid,
  input wire       out_last,
  input wire [5:0] led_status
);

  // Last marker rides on a valid beat
  a_last_needs_valid: assert property (@(posedge clk) disable iff (reset)
    out_last |-> out_valid)
    else $error("out_last high without out_valid");

  // Quiet output during reset
  a_quiet_in_reset: assert property (@(posedge clk) reset |=> !out_valid)
    else $error("out_valid high during reset");

  // And in the first cycle after release
  a_quiet_after_reset: assert property (@(posedge clk) $fell(reset) |=> !out_valid)
    else $error("out_valid high right after reset");

  // Input and ALU error never shown together
  a_one_error_led: assert property (@(posedge clk) disable iff (reset)
    !(led_status[4] && led_status[5]))
    else $error("both error LEDs set");

endmodule

bind matrix_calc_core matrix_calc_properties i_props (
  .clk(clk), .reset(reset), .out_valid(out_valid), .out_last(out_last),
  .led_status(led_status)
);

`default_nettype wire

/* dv/result_checker.sv */
// Output checker for the matrix calculator
// Compares streamed beats and error LEDs per test, prints per-test and total counts
`timescale 1ns/1ps
`default_nettype none

module result_checker (
  input  wire                       clk,
  input  wire                       reset,
  input  wire matrix_pkg::element_t out_data,
  input  wire                       out_valid,
  input  wire                       out_last,
  input  wire [5:0]                 led_status,
  input  wire                       arm,
  input  wire                       test_done,
  input  wire                       report,
  input  wire [7:0]                 test_id,
  input  wire [71:0]                exp_data,
  input  wire [3:0]                 exp_count,
  input  wire [1:0]                 exp_err,
  output int                        error_count
);

  logic [3:0]           beat;
  logic [1:0]           seen_err;
  int                   test_errors;
  int                   tests_run;
  matrix_pkg::element_t exp_el;

  task automatic flag_mismatch(input string msg);
    $display("mismatch at %0t: test %0d, %s", $time, test_id, msg);
    test_errors++;
    error_count++;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      beat        = 4'd0;
      seen_err    = 2'b00;
      test_errors = 0;
      tests_run   = 0;
      error_count = 0;
    end else begin
      if (arm) begin
        beat        = 4'd0;
        seen_err    = 2'b00;
        test_errors = 0;
      end else begin
        // Sticky error LEDs over the test window
        seen_err = seen_err | led_status[5:4];
        if (out_valid) begin
          if (beat >= exp_count) begin
            flag_mismatch($sformatf("unexpected beat %0d, data %02h", beat, out_data));
          end else begin
            exp_el = exp_data[8*beat +: 8];
            if (out_data !== exp_el)
              flag_mismatch($sformatf("beat %0d data %02h, expected %02h", beat, out_data, exp_el));
            // Last marker only on the final element
            if (out_last !== (beat == exp_count - 4'd1))
              flag_mismatch($sformatf("beat %0d out_last %b", beat, out_last));
          end
          beat = beat + 4'd1;
        end
      end
      if (test_done) begin
        if (beat != exp_count)
          flag_mismatch($sformatf("%0d beats, expected %0d", beat, exp_count));
        if (seen_err != exp_err)
          flag_mismatch($sformatf("error LEDs %b, expected %b", seen_err, exp_err));
        tests_run++;
        if (test_errors == 0) $display("test %0d passed, %0d beats", test_id, beat);
        else $display("test %0d failed with %0d errors", test_id, test_errors);
      end
      if (report) $display("tests run %0d, errors %0d", tests_run, error_count);
    end
  end

endmodule

`default_nettype wire

/* dv/tb_matrix_calc.sv */
// Testbench top for the matrix calculator core
// Clock, reset, stimulus table, xorshift element source and slot reference model
`timescale 1ns/1ps
`default_nettype none

module tb_matrix_calc;

  localparam int NUM_TESTS  = 14;
  localparam int WAIT_LIMIT = 300;

  // Test kinds
  localparam logic [1:0] K_FRAME = 2'd0;
  localparam logic [1:0] K_CALC  = 2'd1;
  localparam logic [1:0] K_BAD   = 2'd2;
  localparam logic [1:0] K_ESC   = 2'd3;

  typedef struct packed {
    logic [1:0]           kind;
    logic [2:0]           rows;
    logic [2:0]           cols;
    logic [3:0]           esc_after;
    matrix_pkg::op_code_t op;
    logic [1:0]           id_a;
    logic [1:0]           id_b;
    logic [7:0]           scalar;
    logic                 expect_err;
  } test_entry_t;

  // DUT side
  logic                   clk, reset;
  matrix_pkg::element_t   rx_byte;
  logic                   rx_valid;
  matrix_pkg::mode_t      sw_mode_sel;
  matrix_pkg::op_code_t   sw_op;
  logic [1:0]             sw_id_a, sw_id_b;
  matrix_pkg::element_t   sw_scalar_val;
  logic                   btn_confirm, btn_esc;
  matrix_pkg::element_t   out_data;
  logic                   out_valid, out_last;
  logic [5:0]             led_status;

  // Checker side
  logic        arm, test_done, report;
  logic [7:0]  test_id;
  logic [71:0] exp_data;
  logic [3:0]  exp_count;
  logic [1:0]  exp_err;
  int          error_count;

  // Reference slot model
  test_entry_t tests [NUM_TESTS];
  logic [7:0]  mdl_data [4][3][3];
  int          mdl_rows [4];
  int          mdl_cols [4];
  int          next_slot;
  logic [31:0] rng;
  logic        timed_out;

  matrix_calc_core i_matrix_calc_core (
    .clk(clk), .reset(reset), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .sw_mode_sel(sw_mode_sel), .sw_op(sw_op), .sw_id_a(sw_id_a), .sw_id_b(sw_id_b),
    .sw_scalar_val(sw_scalar_val), .btn_confirm(btn_confirm), .btn_esc(btn_esc),
    .out_data(out_data), .out_valid(out_valid), .out_last(out_last),
    .led_status(led_status)
  );

  result_checker i_result_checker (
    .clk(clk), .reset(reset), .out_data(out_data), .out_valid(out_valid),
    .out_last(out_last), .led_status(led_status), .arm(arm), .test_done(test_done),
    .report(report), .test_id(test_id), .exp_data(exp_data), .exp_count(exp_count),
    .exp_err(exp_err), .error_count(error_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ====================
  // Helpers
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Poll LEDs each edge until any masked bit is set
  task automatic wait_led(input logic [5:0] mask, input string what);
    int n;
    n = 0;
    @(posedge clk);
    while (((led_status & mask) == 6'd0) && !timed_out) begin
      if (n == WAIT_LIMIT) begin
        $display("timeout: %s never reached in test %0d", what, test_id);
        timed_out = 1'b1;
      end else begin
        @(posedge clk);
        n++;
      end
    end
  endtask

  task automatic press_confirm();
    @(posedge clk);
    btn_confirm <= 1'b1;
    @(posedge clk);
    btn_confirm <= 1'b0;
  endtask

  task automatic press_esc();
    @(posedge clk);
    btn_esc <= 1'b1;
    @(posedge clk);
    btn_esc <= 1'b0;
  endtask

  task automatic send_byte(input logic [7:0] b);
    @(posedge clk);
    rx_byte  <= b;
    rx_valid <= 1'b1;
    @(posedge clk);
    rx_valid <= 1'b0;
  endtask

  // Load expectations into the checker and clear its per-test state
  task automatic start_test(input int id, input logic [71:0] ev, input int cnt,
                            input logic [1:0] err);
    @(posedge clk);
    test_id   <= 8'(id);
    exp_data  <= ev;
    exp_count <= 4'(cnt);
    exp_err   <= err;
    arm       <= 1'b1;
    @(posedge clk);
    arm <= 1'b0;
  endtask

  task automatic finish_test();
    @(posedge clk);
    test_done <= 1'b1;
    @(posedge clk);
    test_done <= 1'b0;
  endtask

  // ====================
  // Matrix entry, bad dims and escaped frames
  task automatic enter_frame(input int id, input test_entry_t t);
    int         slot;
    int         cols_i;
    int         total;
    logic [7:0] v;
    slot   = next_slot;
    cols_i = int'(t.cols);
    start_test(id, 72'd0, 0, (t.kind == K_BAD) ? 2'b01 : 2'b00);
    sw_mode_sel <= matrix_pkg::MODE_INPUT;
    press_confirm();
    wait_led(6'b000010, "input state");
    if (t.kind == K_BAD) begin
      // Rejected frame leaves the slot pointer alone
      send_byte({5'd0, t.rows});
      wait_led(6'b010000, "input error LED");
      press_confirm();
    end else begin
      send_byte({5'd0, t.rows});
      send_byte({5'd0, t.cols});
      // New-matrix strobe clears the target slot
      mdl_rows[slot] = int'(t.rows);
      mdl_cols[slot] = cols_i;
      for (int r = 0; r < 3; r++) begin
        for (int c = 0; c < 3; c++) begin
          mdl_data[slot][r][c] = 8'd0;
        end
      end
      total = (t.kind == K_ESC) ? int'(t.esc_after) : int'(t.rows) * cols_i;
      for (int k = 0; k < total; k++) begin
        rng = xorshift32(rng);
        v   = rng[7:0];
        send_byte(v);
        mdl_data[slot][k / cols_i][k % cols_i] = v;
      end
      if (t.kind == K_ESC) press_esc();
      else next_slot = (next_slot + 1) % 4;
    end
    wait_led(6'b000001, "idle state");
    finish_test();
  endtask

  // ====================
  // ALU command with expected result from the model
  task automatic run_calc(input int id, input test_entry_t t);
    logic [71:0] ev;
    int          cnt;
    int          a;
    int          b;
    a   = int'(t.id_a);
    b   = int'(t.id_b);
    ev  = 72'd0;
    cnt = 0;
    if (!t.expect_err) begin
      case (t.op)
        matrix_pkg::OP_ADD, matrix_pkg::OP_SCALAR_MUL: begin
          for (int r = 0; r < mdl_rows[a]; r++) begin
            for (int c = 0; c < mdl_cols[a]; c++) begin
              // 8-bit context wraps modulo 256
              if (t.op == matrix_pkg::OP_ADD) begin
                ev[8*cnt +: 8] = mdl_data[a][r][c] + mdl_data[b][r][c];
              end else begin
                ev[8*cnt +: 8] = mdl_data[a][r][c] * t.scalar;
              end
              cnt++;
            end
          end
        end
        matrix_pkg::OP_TRANSPOSE: begin
          // Result row i is source column i
          for (int i = 0; i < mdl_cols[a]; i++) begin
            for (int j = 0; j < mdl_rows[a]; j++) begin
              ev[8*cnt +: 8] = mdl_data[a][j][i];
              cnt++;
            end
          end
        end
        default: cnt = 0;
      endcase
    end
    start_test(id, ev, cnt, t.expect_err ? 2'b10 : 2'b00);
    sw_mode_sel   <= matrix_pkg::MODE_CALC;
    sw_op         <= t.op;
    sw_id_a       <= t.id_a;
    sw_id_b       <= t.id_b;
    sw_scalar_val <= t.scalar;
    press_confirm();
    wait_led(6'b000100, "calc state");
    if (t.expect_err) begin
      wait_led(6'b100000, "ALU error LED");
      press_confirm();
    end else begin
      wait_led(6'b001000, "print state");
    end
    wait_led(6'b000001, "idle state");
    finish_test();
  endtask

  // ====================
  // Main sequence
  initial begin
    reset         = 1'b1;
    rx_byte       = 8'd0;
    rx_valid      = 1'b0;
    sw_mode_sel   = matrix_pkg::MODE_INPUT;
    sw_op         = matrix_pkg::OP_ADD;
    sw_id_a       = 2'd0;
    sw_id_b       = 2'd0;
    sw_scalar_val = 8'd0;
    btn_confirm   = 1'b0;
    btn_esc       = 1'b0;
    arm           = 1'b0;
    test_done     = 1'b0;
    report        = 1'b0;
    test_id       = 8'd0;
    exp_data      = 72'd0;
    exp_count     = 4'd0;
    exp_err       = 2'b00;
    rng           = 32'd13854;
    next_slot     = 0;
    timed_out     = 1'b0;
    for (int s = 0; s < 4; s++) begin
      mdl_rows[s] = 0;
      mdl_cols[s] = 0;
    end

    // kind, rows, cols, esc_after, op, id_a, id_b, scalar, expect_err
    tests[0]  = '{K_FRAME, 3'd2, 3'd3, 4'd0, matrix_pkg::OP_ADD,        2'd0, 2'd0, 8'h00, 1'b0};
    tests[1]  = '{K_CALC,  3'd0, 3'd0, 4'd0, matrix_pkg::OP_TRANSPOSE,  2'd0, 2'd0, 8'h00, 1'b0};
    tests[2]  = '{K_FRAME, 3'd3, 3'd3, 4'd0, matrix_pkg::OP_ADD,        2'd0, 2'd0, 8'h00, 1'b0};
    tests[3]  = '{K_FRAME, 3'd3, 3'd3, 4'd0, matrix_pkg::OP_ADD,        2'd0, 2'd0, 8'h00, 1'b0};
    tests[4]  = '{K_CALC,  3'd0, 3'd0, 4'd0, matrix_pkg::OP_ADD,        2'd1, 2'd2, 8'h00, 1'b0};
    tests[5]  = '{K_CALC,  3'd0, 3'd0, 4'd0, matrix_pkg::OP_SCALAR_MUL, 2'd1, 2'd0, 8'hb7, 1'b0};
    tests[6]  = '{K_CALC,  3'd0, 3'd0, 4'd0, matrix_pkg::OP_ADD,        2'd0, 2'd1, 8'h00, 1'b1};
    tests[7]  = '{K_BAD,   3'd4, 3'd2, 4'd0, matrix_pkg::OP_ADD,        2'd0, 2'd0, 8'h00, 1'b0};
    tests[8]  = '{K_FRAME, 3'd3, 3'd2, 4'd0, matrix_pkg::OP_ADD,        2'd0, 2'd0, 8'h00, 1'b0};
    tests[9]  = '{K_CALC,  3'd0, 3'd0, 4'd0, matrix_pkg::OP_TRANSPOSE,  2'd3, 2'd0, 8'h00, 1'b0};
    tests[10] = '{K_ESC,   3'd2, 3'd2, 4'd2, matrix_pkg::OP_ADD,        2'd0, 2'd0, 8'h00, 1'b0};
    tests[11] = '{K_CALC,  3'd0, 3'd0, 4'd0, matrix_pkg::OP_TRANSPOSE,  2'd3, 2'd0, 8'h00, 1'b0};
    tests[12] = '{K_FRAME, 3'd1, 3'd2, 4'd0, matrix_pkg::OP_ADD,        2'd0, 2'd0, 8'h00, 1'b0};
    tests[13] = '{K_CALC,  3'd0, 3'd0, 4'd0, matrix_pkg::OP_SCALAR_MUL, 2'd0, 2'd0, 8'h05, 1'b0};

    repeat (4) @(posedge clk);
    reset <= 1'b0;

    for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
      if (tests[t].kind == K_CALC) run_calc(t, tests[t]);
      else enter_frame(t, tests[t]);
    end

    // Counts line from the checker before the verdict
    @(posedge clk);
    report <= 1'b1;
    @(posedge clk);
    report <= 1'b0;
    @(posedge clk);
    if (timed_out || error_count != 0) begin
      $display("Checks failed");
    end else begin
      $display("All checks passed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
rtl/matrix_pkg.sv
rtl/main_fsm.sv
rtl/matrix_input.sv
rtl/matrix_storage.sv
rtl/matrix_alu.sv
rtl/result_streamer.sv
rtl/matrix_calc_core.sv
dv/matrix_calc_properties.sv
dv/result_checker.sv
dv/tb_matrix_calc.sv

/* rtl/main_fsm.sv */
// Top control FSM of the calculator
// Sequences matrix input, ALU run and result output, drives status LEDs
`timescale 1ns/1ps
`default_nettype none

module main_fsm (
  input  wire                    clk,
  input  wire                    reset,
  input  wire matrix_pkg::mode_t sw_mode_sel,
  input  wire                    btn_confirm,
  input  wire                    btn_esc,
  input  wire                    input_done,
  input  wire                    input_err,
  input  wire                    alu_done,
  input  wire                    alu_err,
  input  wire                    print_done,
  output matrix_pkg::sys_state_t state,
  output logic                   input_en,
  output logic                   alu_start,
  output logic                   print_start,
  output logic [5:0]             led_status
);

  // Error kind for the error state, 1 means ALU error
  logic err_is_alu;

  // ====================
  // State register
  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= matrix_pkg::STATE_IDLE;
      alu_start   <= 1'b0;
      print_start <= 1'b0;
      err_is_alu  <= 1'b0;
    end else begin
      // Strobes last one cycle
      alu_start   <= 1'b0;
      print_start <= 1'b0;
      case (state)
        matrix_pkg::STATE_IDLE: begin
          if (btn_confirm) begin
            if (sw_mode_sel == matrix_pkg::MODE_INPUT) begin
              state <= matrix_pkg::STATE_INPUT;
            end else begin
              state     <= matrix_pkg::STATE_CALC;
              alu_start <= 1'b1;
            end
          end
        end
        matrix_pkg::STATE_INPUT: begin
          // Esc drops the partial frame
          if (btn_esc) begin
            state <= matrix_pkg::STATE_IDLE;
          end else if (input_err) begin
            state      <= matrix_pkg::STATE_ERROR_SHOW;
            err_is_alu <= 1'b0;
          end else if (input_done) begin
            state <= matrix_pkg::STATE_IDLE;
          end
        end
        matrix_pkg::STATE_CALC: begin
          if (alu_err) begin
            state      <= matrix_pkg::STATE_ERROR_SHOW;
            err_is_alu <= 1'b1;
          end else if (alu_done) begin
            state       <= matrix_pkg::STATE_PRINT;
            print_start <= 1'b1;
          end
        end
        matrix_pkg::STATE_PRINT: begin
          if (print_done) state <= matrix_pkg::STATE_IDLE;
        end
        matrix_pkg::STATE_ERROR_SHOW: begin
          // Hold until the user acknowledges
          if (btn_confirm || btn_esc) state <= matrix_pkg::STATE_IDLE;
        end
        default: state <= matrix_pkg::STATE_IDLE;
      endcase
    end
  end

  assign input_en = (state == matrix_pkg::STATE_INPUT);

  // ====================
  // LEDs, one-hot state plus error kind
  always_comb begin
    led_status    = '0;
    led_status[0] = (state == matrix_pkg::STATE_IDLE);
    led_status[1] = (state == matrix_pkg::STATE_INPUT);
    led_status[2] = (state == matrix_pkg::STATE_CALC);
    led_status[3] = (state == matrix_pkg::STATE_PRINT);
    led_status[4] = (state == matrix_pkg::STATE_ERROR_SHOW) && !err_is_alu;
    led_status[5] = (state == matrix_pkg::STATE_ERROR_SHOW) && err_is_alu;
  end

endmodule

`default_nettype wire

/* rtl/matrix_alu.sv */
// Element-serial matrix ALU
// Add, scalar multiply and transpose, one element per cycle
// Dims check for add
`timescale 1ns/1ps
`default_nettype none

module matrix_alu (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         alu_start,
  input  wire matrix_pkg::op_code_t   op,
  input  wire matrix_pkg::matrix_t    mat_a,
  input  wire matrix_pkg::matrix_t    mat_b,
  input  wire matrix_pkg::element_t   scalar,
  output matrix_pkg::matrix_t         result,
  output logic                        alu_done,
  output logic                        alu_err
);

  logic                         busy;
  logic [matrix_pkg::DIM_W-1:0] r, c;
  logic [matrix_pkg::DIM_W-1:0] dst_r, dst_c;
  logic                         at_last;
  logic                         dims_match;
  matrix_pkg::element_t         a_el, b_el, elem_val;

  assign dims_match = (mat_a.dims == mat_b.dims);
  assign at_last    = (r == mat_a.dims.rows - 1'b1) && (c == mat_a.dims.cols - 1'b1);

  // ====================
  // Element datapath
  always_comb begin
    a_el = mat_a.data[r][c];
    b_el = mat_b.data[r][c];
    case (op)
      matrix_pkg::OP_ADD:        elem_val = a_el + b_el;
      matrix_pkg::OP_SCALAR_MUL: elem_val = a_el * scalar;
      default:                   elem_val = a_el;
    endcase
    // Transpose writes to the mirrored cell
    dst_r = (op == matrix_pkg::OP_TRANSPOSE) ? c : r;
    dst_c = (op == matrix_pkg::OP_TRANSPOSE) ? r : c;
  end

  // ====================
  // Walk control
  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      r        <= '0;
      c        <= '0;
      alu_done <= 1'b0;
      alu_err  <= 1'b0;
    end else begin
      alu_done <= 1'b0;
      alu_err  <= 1'b0;
      if (alu_start) begin
        if (op == matrix_pkg::OP_ADD && !dims_match) begin
          alu_err <= 1'b1;
        end else begin
          busy <= 1'b1;
          r    <= '0;
          c    <= '0;
        end
      end else if (busy) begin
        if (at_last) begin
          busy     <= 1'b0;
          alu_done <= 1'b1;
        end else if (c == mat_a.dims.cols - 1'b1) begin
          c <= '0;
          r <= r + 1'b1;
        end else begin
          c <= c + 1'b1;
        end
      end
    end
  end

  // Result register, dims set at start
  always_ff @(posedge clk) begin
    if (alu_start) begin
      result <= '0;
      if (op == matrix_pkg::OP_TRANSPOSE) begin
        result.dims.rows <= mat_a.dims.cols;
        result.dims.cols <= mat_a.dims.rows;
      end else begin
        result.dims <= mat_a.dims;
      end
    end else if (busy) begin
      result.data[dst_r][dst_c] <= elem_val;
    end
  end

endmodule

`default_nettype wire

/* rtl/matrix_calc_core.sv */
// Calculator top level
// Control FSM, input parser, slot store, ALU and result streamer
`timescale 1ns/1ps
`default_nettype none

module matrix_calc_core (
  input  wire                             clk,
  input  wire                             reset,
  input  wire matrix_pkg::element_t       rx_byte,
  input  wire                             rx_valid,
  input  wire matrix_pkg::mode_t          sw_mode_sel,
  input  wire matrix_pkg::op_code_t       sw_op,
  input  wire [matrix_pkg::SLOT_W-1:0]    sw_id_a,
  input  wire [matrix_pkg::SLOT_W-1:0]    sw_id_b,
  input  wire matrix_pkg::element_t       sw_scalar_val,
  input  wire                             btn_confirm,
  input  wire                             btn_esc,
  output matrix_pkg::element_t            out_data,
  output logic                            out_valid,
  output logic                            out_last,
  output logic [5:0]                      led_status
);

  // ====================
  // Interconnect
  matrix_pkg::mat_wr_t    wr;
  matrix_pkg::matrix_t    rd_a, rd_b, result;
  logic input_en, alu_start, print_start;
  logic input_done, input_err, alu_done, alu_err, print_done;

  // Control
  main_fsm u_fsm (
    .clk, .reset, .sw_mode_sel, .btn_confirm, .btn_esc,
    .input_done, .input_err, .alu_done, .alu_err, .print_done,
    .state(), .input_en, .alu_start, .print_start, .led_status
  );

  // Byte stream parser
  matrix_input u_input (
    .clk, .reset, .input_en, .btn_esc, .rx_byte, .rx_valid,
    .wr, .input_done, .input_err
  );

  // Operand ids come straight from the switches
  matrix_storage u_storage (
    .clk, .reset, .wr, .rd_id_a(sw_id_a), .rd_id_b(sw_id_b), .rd_a, .rd_b
  );

  matrix_alu u_alu (
    .clk, .reset, .alu_start, .op(sw_op), .mat_a(rd_a), .mat_b(rd_b),
    .scalar(sw_scalar_val), .result, .alu_done, .alu_err
  );

  result_streamer u_streamer (
    .clk, .reset, .print_start, .result,
    .out_data, .out_valid, .out_last, .print_done
  );

endmodule

`default_nettype wire

/* rtl/matrix_input.sv */
// Byte stream parser for matrix entry
// Rows byte, cols byte, then elements in row-major order
`timescale 1ns/1ps
`default_nettype none

module matrix_input (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       input_en,
  input  wire                       btn_esc,
  input  wire matrix_pkg::element_t rx_byte,
  input  wire                       rx_valid,
  output matrix_pkg::mat_wr_t       wr,
  output logic                      input_done,
  output logic                      input_err
);

  typedef enum logic [1:0] {P_ROWS, P_COLS, P_ELEMS} parse_t;

  parse_t                       pstate;
  logic [matrix_pkg::DIM_W-1:0] rows_q, cols_q;
  logic [matrix_pkg::DIM_W-1:0] row_cnt, col_cnt;
  logic                         dim_ok;
  logic                         last_elem;
  logic                         take;

  // Dims must be 1..MAX_DIM
  assign dim_ok    = (rx_byte != '0) && (int'(rx_byte) <= matrix_pkg::MAX_DIM);
  assign last_elem = (row_cnt == rows_q - 1'b1) && (col_cnt == cols_q - 1'b1);
  assign take      = input_en && rx_valid && !btn_esc;

  // ====================
  // Storage write, lands on the edge of the carrying byte
  always_comb begin
    wr           = '0;
    wr.dims.rows = rows_q;
    wr.dims.cols = rx_byte[matrix_pkg::DIM_W-1:0];
    wr.row       = row_cnt;
    wr.col       = col_cnt;
    wr.data      = rx_byte;
    wr.new_mat   = take && (pstate == P_COLS) && dim_ok;
    wr.elem      = take && (pstate == P_ELEMS);
  end

  // ====================
  // Parse state and counters
  always_ff @(posedge clk) begin
    if (reset) begin
      pstate     <= P_ROWS;
      rows_q     <= '0;
      cols_q     <= '0;
      row_cnt    <= '0;
      col_cnt    <= '0;
      input_done <= 1'b0;
      input_err  <= 1'b0;
    end else begin
      input_done <= 1'b0;
      input_err  <= 1'b0;
      if (!input_en || btn_esc) begin
        pstate <= P_ROWS;
      end else if (rx_valid) begin
        case (pstate)
          P_ROWS: begin
            if (dim_ok) begin
              rows_q <= rx_byte[matrix_pkg::DIM_W-1:0];
              pstate <= P_COLS;
            end else begin
              input_err <= 1'b1;
            end
          end
          P_COLS: begin
            if (dim_ok) begin
              cols_q  <= rx_byte[matrix_pkg::DIM_W-1:0];
              row_cnt <= '0;
              col_cnt <= '0;
              pstate  <= P_ELEMS;
            end else begin
              input_err <= 1'b1;
              pstate    <= P_ROWS;
            end
          end
          P_ELEMS: begin
            if (last_elem) begin
              input_done <= 1'b1;
              pstate     <= P_ROWS;
            end else if (col_cnt == cols_q - 1'b1) begin
              // Wrap to next row
              col_cnt <= '0;
              row_cnt <= row_cnt + 1'b1;
            end else begin
              col_cnt <= col_cnt + 1'b1;
            end
          end
          default: pstate <= P_ROWS;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/matrix_pkg.sv */
// Shared sizes and element types for the matrix calculator
// Matrix, dimension and storage write port structs
// State, mode and opcode enums
`default_nettype none

package matrix_pkg;

  // ====================
  // Sizes
  localparam int MAX_DIM   = 3;
  localparam int MAT_SLOTS = 4;
  localparam int ELEM_W    = 8;
  localparam int DIM_W     = 2;
  localparam int SLOT_W    = 2;

  // ====================
  // Data types
  // Unsigned element, arithmetic wraps modulo 256
  typedef logic [ELEM_W-1:0] element_t;

  typedef struct packed {
    logic [DIM_W-1:0] rows;
    logic [DIM_W-1:0] cols;
  } mat_dims_t;

  // Row-major cells, unused ones stay zero
  typedef struct packed {
    mat_dims_t                               dims;
    element_t [MAX_DIM-1:0][MAX_DIM-1:0] data;
  } matrix_t;

  // Storage write port
  typedef struct packed {
    logic             new_mat;
    mat_dims_t        dims;
    logic             elem;
    logic [DIM_W-1:0] row;
    logic [DIM_W-1:0] col;
    element_t         data;
  } mat_wr_t;

  // ====================
  // Enums
  typedef enum logic [1:0] {OP_ADD, OP_SCALAR_MUL, OP_TRANSPOSE} op_code_t;

  typedef enum logic {MODE_INPUT, MODE_CALC} mode_t;

  typedef enum logic [2:0] {
    STATE_IDLE,
    STATE_INPUT,
    STATE_CALC,
    STATE_PRINT,
    STATE_ERROR_SHOW
  } sys_state_t;

endpackage

`default_nettype wire

/* rtl/matrix_storage.sv */
// Matrix slot store with two combinational read ports
// Owns the next-slot pointer used by input frames
`timescale 1ns/1ps
`default_nettype none

module matrix_storage (
  input  wire                                    clk,
  input  wire                                    reset,
  input  wire matrix_pkg::mat_wr_t               wr,
  input  wire [matrix_pkg::SLOT_W-1:0]           rd_id_a,
  input  wire [matrix_pkg::SLOT_W-1:0]           rd_id_b,
  output matrix_pkg::matrix_t                    rd_a,
  output matrix_pkg::matrix_t                    rd_b
);

  matrix_pkg::matrix_t           slots [matrix_pkg::MAT_SLOTS];
  logic [matrix_pkg::SLOT_W-1:0] next_slot;
  matrix_pkg::mat_dims_t         tgt_dims;
  logic                          last_wr;

  // Dims of the slot being filled
  assign tgt_dims = slots[next_slot].dims;

  // Frame complete on the bottom-right cell
  assign last_wr = wr.elem
                && (wr.row == tgt_dims.rows - 1'b1)
                && (wr.col == tgt_dims.cols - 1'b1);

  // ====================
  // Write side
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < matrix_pkg::MAT_SLOTS; i++) begin
        slots[i] <= '0;
      end
      next_slot <= '0;
    end else begin
      if (wr.new_mat) begin
        // Fresh frame, clear old cells
        slots[next_slot]      <= '0;
        slots[next_slot].dims <= wr.dims;
      end else if (wr.elem) begin
        slots[next_slot].data[wr.row][wr.col] <= wr.data;
      end
      // Pointer wraps modulo slot count
      if (last_wr) next_slot <= next_slot + 1'b1;
    end
  end

  // ====================
  // Read side
  assign rd_a = slots[rd_id_a];
  assign rd_b = slots[rd_id_b];

endmodule

`default_nettype wire

/* rtl/result_streamer.sv */
// Result streamer, one element per cycle in row-major order
`timescale 1ns/1ps
`default_nettype none

module result_streamer (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       print_start,
  input  wire matrix_pkg::matrix_t  result,
  output matrix_pkg::element_t      out_data,
  output logic                      out_valid,
  output logic                      out_last,
  output logic                      print_done
);

  logic                         active;
  logic [matrix_pkg::DIM_W-1:0] r, c;
  logic                         at_last;

  assign at_last = (r == result.dims.rows - 1'b1) && (c == result.dims.cols - 1'b1);

  always_ff @(posedge clk) begin
    if (reset) begin
      active     <= 1'b0;
      r          <= '0;
      c          <= '0;
      out_valid  <= 1'b0;
      out_last   <= 1'b0;
      print_done <= 1'b0;
    end else begin
      out_valid  <= active;
      out_last   <= active && at_last;
      // Done trails the last beat
      print_done <= out_last;
      if (print_start) begin
        active <= 1'b1;
        r      <= '0;
        c      <= '0;
      end else if (active) begin
        if (at_last) active <= 1'b0;
        else if (c == result.dims.cols - 1'b1) begin
          c <= '0;
          r <= r + 1'b1;
        end else c <= c + 1'b1;
      end
    end
  end

  // Payload follows the walk pointer
  always_ff @(posedge clk) begin
    out_data <= result.data[r][c];
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the matrix calculator testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module tb_matrix_calc \
  -o sim_matrix_calc \
  && ./obj_dir/sim_matrix_calc > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
